//--- logic/noc_router_pkg.sv
package noc_router_pkg;

        // ##############################
        // router dimensions
        // ##############################

        localparam int NUM_PORTS = 5;     // n, s, w, e, local
        localparam int PORT_W    = 3;     // bits of a port code

        // ##############################
        // port codes
        // ##############################

        typedef enum logic [PORT_W-1:0] {
                port_north = 3'd0,
                port_south = 3'd1,
                port_west  = 3'd2,
                port_east  = 3'd3,
                port_local = 3'd4
        } port_e;

        // ##############################
        // request and grant words
        // ##############################

        // what one input asks of the switch
        typedef struct packed {
                logic  valid;             // input holds a flit
                port_e next_hop;          // output it wants
        } port_req_t;

        // one bit per port, indexed by port code
        typedef logic [NUM_PORTS-1:0] port_vec_t;

        // crossbar select carries the granted input's code
        typedef logic [PORT_W-1:0] sel_t;

endpackage

//--- logic/port_request_decoder.sv
module port_request_decoder (
        input  noc_router_pkg::port_req_t req_i     [noc_router_pkg::NUM_PORTS],
        output noc_router_pkg::port_vec_t out_req_o [noc_router_pkg::NUM_PORTS]
);

        localparam int N = noc_router_pkg::NUM_PORTS;

        logic [N-1:0] hop_ok;             // valid with a legal code

        // ##############################
        // input side qualification
        // ##############################

        always_comb begin
                for (int i = 0; i < N; i++) begin
                        hop_ok[i] = req_i[i].valid && (int'(req_i[i].next_hop) < N);
                end
        end

        // ##############################
        // transpose to output side
        // ##############################

        // output o sees bit i when input i aims at o, never from o itself
        always_comb begin
                for (int o = 0; o < N; o++) begin
                        out_req_o[o] = '0;
                        for (int i = 0; i < N; i++) begin
                                if (hop_ok[i] && (int'(req_i[i].next_hop) == o) && (i != o)) begin
                                        out_req_o[o][i] = 1'b1;
                                end
                        end
                end
        end

endmodule

//--- logic/rr_pointer.sv
module rr_pointer (
        input  logic                      clk,
        input  logic                      reset_i,
        input  logic                      change_order_i,
        input  noc_router_pkg::port_vec_t grant_i,
        output noc_router_pkg::port_e     pointer_o
);

        localparam int N = noc_router_pkg::NUM_PORTS;

        noc_router_pkg::port_e winner;
        noc_router_pkg::port_e next_ptr;

        // grant is one-hot, take its code
        always_comb begin
                winner = noc_router_pkg::port_north;
                for (int i = 0; i < N; i++) begin
                        if (grant_i[i]) begin
                                winner = noc_router_pkg::port_e'(i);
                        end
                end
        end

        // start just after the winner, local wraps to north
        always_comb begin
                if (winner == noc_router_pkg::port_local) begin
                        next_ptr = noc_router_pkg::port_north;
                end else begin
                        next_ptr = noc_router_pkg::port_e'(winner + 3'd1);
                end
        end

        always_ff @(posedge clk) begin
                if (reset_i) begin
                        pointer_o <= noc_router_pkg::port_north;
                end else if (change_order_i && (|grant_i)) begin
                        pointer_o <= next_ptr;           // strobe only counts with a winner
                end
        end

endmodule

//--- logic/rr_grant_encoder.sv
module rr_grant_encoder (
        input  noc_router_pkg::port_vec_t req_i,
        input  noc_router_pkg::port_e     pointer_i,
        output noc_router_pkg::port_vec_t grant_o,
        output noc_router_pkg::sel_t      sel_o
);

        localparam int N = noc_router_pkg::NUM_PORTS;

        noc_router_pkg::port_vec_t rot_req;  // requests seen from the pointer
        noc_router_pkg::port_vec_t rot_gnt;  // fixed priority result, rotated

        // position base+offs on the ring of ports
        function automatic int wrap_add(input int base, input int offs);
                int sum;
                sum = base + offs;
                if (sum >= N) begin
                        sum = sum - N;
                end
                return sum;
        endfunction

        // ##############################
        // rotate requests by pointer
        // ##############################

        // bit 0 of rot_req is the port the pointer names
        always_comb begin
                for (int k = 0; k < N; k++) begin
                        rot_req[k] = req_i[wrap_add(k, int'(pointer_i))];
                end
        end

        // ##############################
        // fixed priority pick
        // ##############################

        assign rot_gnt = rot_req & (~rot_req + 1'b1);  // lowest set bit

        // ##############################
        // rotate back and encode
        // ##############################

        always_comb begin
                grant_o = '0;
                sel_o   = noc_router_pkg::sel_t'(noc_router_pkg::port_north);
                for (int k = 0; k < N; k++) begin
                        if (rot_gnt[k]) begin
                                grant_o[wrap_add(k, int'(pointer_i))] = 1'b1;
                                sel_o = noc_router_pkg::sel_t'(wrap_add(k, int'(pointer_i)));
                        end
                end
        end

endmodule

//--- logic/rr_output_arbiter.sv
module rr_output_arbiter (
        input  logic                      clk,
        input  logic                      reset_i,
        input  noc_router_pkg::port_vec_t req_i,
        input  logic                      change_order_i,
        output noc_router_pkg::port_vec_t grant_o,
        output noc_router_pkg::sel_t      sel_o
);

        noc_router_pkg::port_e     pointer;   // current top priority input
        noc_router_pkg::port_vec_t grant;

        // ##############################
        // priority state
        // ##############################

        rr_pointer u_pointer (
                .clk            (clk),
                .reset_i        (reset_i),
                .change_order_i (change_order_i),
                .grant_i        (grant),          // winner feeds back
                .pointer_o      (pointer)
        );

        // ##############################
        // grant logic
        // ##############################

        rr_grant_encoder u_encoder (
                .req_i     (req_i),
                .pointer_i (pointer),
                .grant_o   (grant),
                .sel_o     (sel_o)
        );

        assign grant_o = grant;

endmodule

//--- logic/crossbar_switch.sv
module crossbar_switch #(
        parameter int FLIT_W = 32
) (
        input  logic [FLIT_W-1:0]         flit_i   [noc_router_pkg::NUM_PORTS],
        input  noc_router_pkg::sel_t      sel_i    [noc_router_pkg::NUM_PORTS],
        input  noc_router_pkg::port_vec_t active_i,
        output logic [FLIT_W-1:0]         flit_o   [noc_router_pkg::NUM_PORTS],
        output noc_router_pkg::port_vec_t valid_o
);

        localparam int N = noc_router_pkg::NUM_PORTS;

        // ##############################
        // per output mux
        // ##############################

        always_comb begin
                for (int o = 0; o < N; o++) begin
                        flit_o[o]  = '0;          // idle outputs carry zero
                        valid_o[o] = active_i[o];
                        if (active_i[o]) begin
                                flit_o[o] = flit_i[sel_i[o]];
                        end
                end
        end

endmodule

//--- logic/router_switch_alloc.sv
module router_switch_alloc #(
        parameter int FLIT_W = 32
) (
        input  logic                      clk,
        input  logic                      reset_i,
        input  noc_router_pkg::port_req_t req_i          [noc_router_pkg::NUM_PORTS],
        input  logic [FLIT_W-1:0]         flit_i         [noc_router_pkg::NUM_PORTS],
        input  noc_router_pkg::port_vec_t change_order_i,
        output noc_router_pkg::port_vec_t grant_o        [noc_router_pkg::NUM_PORTS],
        output logic [FLIT_W-1:0]         flit_o         [noc_router_pkg::NUM_PORTS],
        output noc_router_pkg::port_vec_t valid_o
);

        localparam int N = noc_router_pkg::NUM_PORTS;

        noc_router_pkg::port_vec_t out_req [N];   // requests per output
        noc_router_pkg::sel_t      sel     [N];
        noc_router_pkg::port_vec_t active;        // output has a winner

        // ##############################
        // request transpose
        // ##############################

        port_request_decoder u_decoder (
                .req_i     (req_i),
                .out_req_o (out_req)
        );

        // ##############################
        // one arbiter per output
        // ##############################

        for (genvar g = 0; g < N; g++) begin : g_arb
                rr_output_arbiter u_arb (
                        .clk            (clk),
                        .reset_i        (reset_i),
                        .req_i          (out_req[g]),
                        .change_order_i (change_order_i[g]),
                        .grant_o        (grant_o[g]),
                        .sel_o          (sel[g])
                );

                assign active[g] = |grant_o[g];
        end

        // ##############################
        // data path
        // ##############################

        crossbar_switch #(
                .FLIT_W (FLIT_W)
        ) u_crossbar (
                .flit_i   (flit_i),
                .sel_i    (sel),
                .active_i (active),
                .flit_o   (flit_o),
                .valid_o  (valid_o)
        );

endmodule

//--- sim/router_switch_alloc_chk.sv
module router_switch_alloc_chk (
        input logic                      clk,
        input logic                      reset_i,
        input noc_router_pkg::port_vec_t req_i,
        input noc_router_pkg::port_vec_t grant_i
);

        // ##############################
        // grant shape
        // ##############################

        one_hot_grant: assert property (@(posedge clk) disable iff (reset_i)
                $onehot0(grant_i))
                else $error("arbiter grant has more than one bit set");

        grant_in_requests: assert property (@(posedge clk) disable iff (reset_i)
                (grant_i & ~req_i) == '0)
                else $error("arbiter granted an input that did not request");

        // work conserving
        grant_when_requested: assert property (@(posedge clk) disable iff (reset_i)
                (|req_i) |-> (|grant_i))
                else $error("arbiter gave no grant while requests were pending");

endmodule

bind rr_output_arbiter router_switch_alloc_chk u_chk (
        .clk     (clk),
        .reset_i (reset_i),
        .req_i   (req_i),
        .grant_i (grant_o)
);

//--- sim/router_switch_alloc_tb.sv
module router_switch_alloc_tb;

        localparam int FLIT_W      = 32;
        localparam int N           = noc_router_pkg::NUM_PORTS;
        localparam int TABLE_LEN   = 15;
        localparam int RAND_CYCLES = 200;

        // next hop codes as the table writes them
        localparam logic [2:0] to_n   = 3'd0;
        localparam logic [2:0] to_s   = 3'd1;
        localparam logic [2:0] to_w   = 3'd2;
        localparam logic [2:0] to_e   = 3'd3;
        localparam logic [2:0] to_l   = 3'd4;
        localparam logic [2:0] to_bad = 3'd5;  // out of range

        typedef struct packed {
                noc_router_pkg::port_vec_t valid;      // inputs holding a flit
                logic [14:0]               hops;       // 3 bits per input
                noc_router_pkg::port_vec_t strobe;     // change order per output
                logic [24:0]               exp_grant;  // 5 bits per output
                noc_router_pkg::port_vec_t exp_valid;
        } step_t;

        logic                      clk;
        logic                      reset_i;
        noc_router_pkg::port_req_t req       [N];
        logic [FLIT_W-1:0]         flit      [N];
        noc_router_pkg::port_vec_t change_order;
        noc_router_pkg::port_vec_t grant     [N];
        logic [FLIT_W-1:0]         flit_out  [N];
        noc_router_pkg::port_vec_t valid_out;

        step_t       steps [TABLE_LEN];
        int          num_steps;
        int          errors;
        logic [31:0] lcg_state;
        int          model_ptr [N];    // priority pointer per output

        router_switch_alloc #(
                .FLIT_W (FLIT_W)
        ) u_dut (
                .clk            (clk),
                .reset_i        (reset_i),
                .req_i          (req),
                .flit_i         (flit),
                .change_order_i (change_order),
                .grant_o        (grant),
                .flit_o         (flit_out),
                .valid_o        (valid_out)
        );

        initial begin
                clk = 1'b0;
                forever #5 clk = ~clk;
        end

        initial begin
                #((TABLE_LEN + RAND_CYCLES + 10) * 10);
                $display("Timeout: the run did not complete in the expected time");
                $display("Finished with errors");
                $fatal(1, "watchdog expired");
        end

        // ##############################
        // helpers
        // ##############################

        function automatic logic [14:0] hops5(input logic [2:0] n, input logic [2:0] s,
                                              input logic [2:0] w, input logic [2:0] e,
                                              input logic [2:0] l);
                return {l, e, w, s, n};
        endfunction

        function automatic logic [24:0] grants5(input noc_router_pkg::port_vec_t gn,
                                                input noc_router_pkg::port_vec_t gs,
                                                input noc_router_pkg::port_vec_t gw,
                                                input noc_router_pkg::port_vec_t ge,
                                                input noc_router_pkg::port_vec_t gl);
                return {gl, ge, gw, gs, gn};
        endfunction

        function automatic logic [31:0] lcg_next();
                lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
                return lcg_state;
        endfunction

        function automatic logic [31:0] flit_for(input int step, input int port);
                return 32'hc0de_0000 | (step << 8) | port;
        endfunction

        function automatic int grant_index(input noc_router_pkg::port_vec_t g);
                int idx;
                idx = -1;
                for (int i = 0; i < N; i++) begin
                        if (g[i]) begin
                                idx = i;
                        end
                end
                return idx;
        endfunction

        // inputs aiming at output o, u-turns and bad codes left out
        function automatic noc_router_pkg::port_vec_t model_req(input int o);
                noc_router_pkg::port_vec_t r;
                r = '0;
                for (int i = 0; i < N; i++) begin
                        if (req[i].valid && (int'(req[i].next_hop) == o) && (i != o)) begin
                                r[i] = 1'b1;
                        end
                end
                return r;
        endfunction

        // first request found from the pointer upward, wrapping
        function automatic noc_router_pkg::port_vec_t model_pick(
                        input noc_router_pkg::port_vec_t r, input int ptr);
                noc_router_pkg::port_vec_t g;
                int                        idx;
                bit                        found;
                g     = '0;
                found = 1'b0;
                for (int k = 0; k < N; k++) begin
                        idx = (ptr + k) % N;
                        if (r[idx] && !found) begin
                                g[idx] = 1'b1;
                                found  = 1'b1;
                        end
                end
                return g;
        endfunction

        task automatic check_value(input string what, input logic [31:0] got,
                                   input logic [31:0] exp);
                if (got !== exp) begin
                        errors++;
                        $display("[FAIL] %0t: %s is %h, expected %h", $time, what, got, exp);
                        $display("Finished with errors");
                        $fatal(1, "mismatch on DUT output");
                end
        endtask

        task automatic check_outputs(input logic [24:0] exp_grant,
                                     input noc_router_pkg::port_vec_t exp_valid,
                                     input string tag);
                noc_router_pkg::port_vec_t g;
                logic [FLIT_W-1:0]         exp_flit;
                int                        w;
                for (int o = 0; o < N; o++) begin
                        g        = exp_grant[o*N +: N];
                        w        = grant_index(g);
                        exp_flit = (w >= 0) ? flit[w] : '0;   // idle output carries zero
                        check_value($sformatf("%s grant_o[%0d]", tag, o), 32'(grant[o]), 32'(g));
                        check_value($sformatf("%s flit_o[%0d]", tag, o), flit_out[o], exp_flit);
                end
                check_value($sformatf("%s valid_o", tag), 32'(valid_out), 32'(exp_valid));
        endtask

        task automatic set_idle;
                change_order = '0;
                for (int i = 0; i < N; i++) begin
                        req[i].valid    = 1'b0;
                        req[i].next_hop = noc_router_pkg::port_north;
                        flit[i]         = '0;
                end
        endtask

        task automatic hold_reset;
                repeat (2) @(posedge clk);
                #1;
                reset_i = 1'b0;
                for (int o = 0; o < N; o++) begin
                        model_ptr[o] = 0;      // pointers start at north
                end
        endtask

        // ##############################
        // directed table
        // ##############################

        task automatic add_step(input noc_router_pkg::port_vec_t valid, input logic [14:0] hops,
                                input noc_router_pkg::port_vec_t strobe,
                                input logic [24:0] exp_grant,
                                input noc_router_pkg::port_vec_t exp_valid);
                steps[num_steps] = '{valid, hops, strobe, exp_grant, exp_valid};
                num_steps++;
        endtask

        task automatic load_steps;
                num_steps = 0;
                add_step(5'b00000, hops5(to_n, to_n, to_n, to_n, to_n), 5'b00000,
                         grants5(5'b00000, 5'b00000, 5'b00000, 5'b00000, 5'b00000), 5'b00000);
                add_step(5'b00001, hops5(to_e, to_n, to_n, to_n, to_n), 5'b00000,
                         grants5(5'b00000, 5'b00000, 5'b00000, 5'b00001, 5'b00000), 5'b01000);
                add_step(5'b00110, hops5(to_n, to_s, to_w, to_n, to_n), 5'b00000,
                         grants5(5'b00000, 5'b00000, 5'b00000, 5'b00000, 5'b00000), 5'b00000);
                // n, s and l fight for west, pointer steps each cycle
                add_step(5'b10011, hops5(to_w, to_w, to_n, to_n, to_w), 5'b00100,
                         grants5(5'b00000, 5'b00000, 5'b00001, 5'b00000, 5'b00000), 5'b00100);
                add_step(5'b10011, hops5(to_w, to_w, to_n, to_n, to_w), 5'b00100,
                         grants5(5'b00000, 5'b00000, 5'b00010, 5'b00000, 5'b00000), 5'b00100);
                add_step(5'b10011, hops5(to_w, to_w, to_n, to_n, to_w), 5'b00100,
                         grants5(5'b00000, 5'b00000, 5'b10000, 5'b00000, 5'b00000), 5'b00100);
                add_step(5'b10011, hops5(to_w, to_w, to_n, to_n, to_w), 5'b00100,
                         grants5(5'b00000, 5'b00000, 5'b00001, 5'b00000, 5'b00000), 5'b00100);
                add_step(5'b10011, hops5(to_w, to_w, to_n, to_n, to_w), 5'b00100,
                         grants5(5'b00000, 5'b00000, 5'b00010, 5'b00000, 5'b00000), 5'b00100);
                // no west strobe, winner holds; south strobe without a grant
                add_step(5'b10111, hops5(to_w, to_w, to_e, to_n, to_w), 5'b00010,
                         grants5(5'b00000, 5'b00000, 5'b10000, 5'b00100, 5'b00000), 5'b01100);
                add_step(5'b10111, hops5(to_w, to_w, to_e, to_n, to_w), 5'b00000,
                         grants5(5'b00000, 5'b00000, 5'b10000, 5'b00100, 5'b00000), 5'b01100);
                add_step(5'b01001, hops5(to_s, to_n, to_n, to_s, to_n), 5'b00010,
                         grants5(5'b00000, 5'b00001, 5'b00000, 5'b00000, 5'b00000), 5'b00010);
                add_step(5'b01001, hops5(to_s, to_n, to_n, to_s, to_n), 5'b00010,
                         grants5(5'b00000, 5'b01000, 5'b00000, 5'b00000, 5'b00000), 5'b00010);
                add_step(5'b01001, hops5(to_s, to_n, to_n, to_s, to_n), 5'b00000,
                         grants5(5'b00000, 5'b00001, 5'b00000, 5'b00000, 5'b00000), 5'b00010);
                // every output busy at once
                add_step(5'b11111, hops5(to_s, to_n, to_e, to_l, to_w), 5'b00000,
                         grants5(5'b00010, 5'b00001, 5'b10000, 5'b00100, 5'b01000), 5'b11111);
                add_step(5'b00001, hops5(to_bad, to_n, to_n, to_n, to_n), 5'b00000,
                         grants5(5'b00000, 5'b00000, 5'b00000, 5'b00000, 5'b00000), 5'b00000);
        endtask

        task automatic run_table;
                for (int k = 0; k < num_steps; k++) begin
                        @(posedge clk);
                        #1;
                        change_order = steps[k].strobe;
                        for (int i = 0; i < N; i++) begin
                                req[i].valid    = steps[k].valid[i];
                                req[i].next_hop = noc_router_pkg::port_e'(steps[k].hops[i*3 +: 3]);
                                flit[i]         = flit_for(k, i);
                        end
                        @(negedge clk);
                        check_outputs(steps[k].exp_grant, steps[k].exp_valid,
                                      $sformatf("step %0d", k));
                end
        endtask

        // ##############################
        // random traffic
        // ##############################

        task automatic run_random;
                logic [31:0]               r;
                noc_router_pkg::port_vec_t mgnt [N];
                logic [24:0]               exp_grant;
                noc_router_pkg::port_vec_t exp_valid;
                int                        w;
                for (int c = 0; c < RAND_CYCLES; c++) begin
                        @(posedge clk);
                        #1;
                        r            = lcg_next();
                        change_order = r[28:24];
                        for (int i = 0; i < N; i++) begin
                                req[i].valid    = r[16 + i];
                                req[i].next_hop = noc_router_pkg::port_e'(
                                        3'((lcg_next() >> 16) % 32'd6));  // 5 is illegal
                                flit[i]         = lcg_next();
                        end
                        @(negedge clk);
                        exp_valid = '0;
                        for (int o = 0; o < N; o++) begin
                                mgnt[o]             = model_pick(model_req(o), model_ptr[o]);
                                exp_grant[o*N +: N] = mgnt[o];
                                exp_valid[o]        = |mgnt[o];
                        end
                        check_outputs(exp_grant, exp_valid, $sformatf("random %0d", c));
                        for (int o = 0; o < N; o++) begin
                                w = grant_index(mgnt[o]);
                                if (change_order[o] && (w >= 0)) begin
                                        model_ptr[o] = (w + 1) % N;   // just past the winner
                                end
                        end
                end
        endtask

        initial begin
                errors    = 0;
                lcg_state = 32'd16;
                reset_i   = 1'b1;
                set_idle();
                load_steps();
                hold_reset();
                run_table();
                @(posedge clk);
                #1;
                reset_i = 1'b1;
                set_idle();
                hold_reset();
                run_random();
                if (errors == 0) begin
                        $display("Finished with no errors");
                end else begin
                        $display("Finished with errors");
                end
                $finish;
        end

endmodule

//--- sim.f
logic/noc_router_pkg.sv
logic/port_request_decoder.sv
logic/rr_pointer.sv
logic/rr_grant_encoder.sv
logic/rr_output_arbiter.sv
logic/crossbar_switch.sv
logic/router_switch_alloc.sv
sim/router_switch_alloc_chk.sv
sim/router_switch_alloc_tb.sv

//--- run.sh
#!/bin/sh
# compile with verilator, run, and look for the pass line

verilator --binary --assert --top-module router_switch_alloc_tb -f sim.f \
        -o router_switch_alloc_sim || { echo "build failed"; exit 1; }

out=$(./obj_dir/router_switch_alloc_sim 2>&1)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "Finished with no errors" \
        && echo "simulation passed" || { echo "simulation failed"; exit 1; }
